/* common/fft_pkg.sv */
package fft_pkg;

    // ------------------------------------------------------------------------
    // sizes
    // ------------------------------------------------------------------------
    localparam int N_POINTS = 16;
    localparam int ADDR_W   = 4;
    localparam int PAIR_W   = ADDR_W - 1;
    localparam int DATA_W   = 16;
    localparam int TW_FRAC  = 14;
    localparam int ANGLE_W  = 2;
    localparam int N_ANGLES = 1 << ANGLE_W;

    // full product width, rotated operand width and sum width
    localparam int PROD_W = 2 * DATA_W + 1;
    localparam int ROT_W  = DATA_W + 2;
    localparam int SUM_W  = ROT_W + 1;

    // second operand strobe to the half-difference write
    localparam int BFLY_LATENCY = 4;
    localparam int DRAIN_W      = $clog2(BFLY_LATENCY);

    // ------------------------------------------------------------------------
    // twiddles, Q2.14, w^k = cos - j*sin for k = 0..3 of 16 points
    // ------------------------------------------------------------------------
    localparam logic signed [DATA_W-1:0] TW_COS [N_ANGLES] = '{
        16'sd16384, 16'sd15137, 16'sd11585, 16'sd6270
    };
    localparam logic signed [DATA_W-1:0] TW_SIN [N_ANGLES] = '{
        16'sd0, -16'sd6270, -16'sd11585, -16'sd15137
    };

    typedef struct packed {
        logic signed [DATA_W-1:0] re;
        logic signed [DATA_W-1:0] im;
    } sample_t;

    typedef enum logic [2:0] {
        IDLE,
        READ_A,
        READ_B,
        DRAIN,
        DONE
    } ctrl_state_e;

endpackage

/* common/sample_wr_if.sv */
`timescale 1ns/1ps

// one complex sample write per clock while en is high
interface sample_wr_if;

    logic                               en;
    logic        [fft_pkg::ADDR_W-1:0]  addr;
    logic signed [fft_pkg::DATA_W-1:0]  re;
    logic signed [fft_pkg::DATA_W-1:0]  im;

    modport writer (
        output en,
        output addr,
        output re,
        output im
    );

    modport mem (
        input en,
        input addr,
        input re,
        input im
    );

endinterface

/* source/sample_ram.sv */
`timescale 1ns/1ps

module sample_ram (
    input  logic                          clk,
    sample_wr_if.mem                      wr,
    input  logic                          rd_en_i,
    input  logic [fft_pkg::ADDR_W-1:0]    rd_addr_i,
    output fft_pkg::sample_t              rd_data_o
);

    fft_pkg::sample_t mem_q [fft_pkg::N_POINTS];

    // ------------------------------------------------------------------------
    // write port
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (wr.en) begin
            mem_q[wr.addr].re <= wr.re;
            mem_q[wr.addr].im <= wr.im;
        end
    end

    // ------------------------------------------------------------------------
    // registered read, holds its last value while rd_en_i is low
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rd_en_i) begin
            rd_data_o <= mem_q[rd_addr_i];
        end
    end

endmodule

/* stage_ctrl/stage_ctrl.sv */
`timescale 1ns/1ps

module stage_ctrl (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          start_i,
    output logic                          rd_en_o,
    output logic [fft_pkg::ADDR_W-1:0]    rd_addr_o,
    output logic                          opa_stb_o,
    output logic                          opb_stb_o,
    output logic [fft_pkg::ANGLE_W-1:0]   angle_o,
    output logic [fft_pkg::ADDR_W-1:0]    pair_addr_o,
    output logic                          done_o
);

    fft_pkg::ctrl_state_e              state_q;
    fft_pkg::ctrl_state_e              state_d;
    logic [fft_pkg::PAIR_W-1:0]        pair_q;
    logic [fft_pkg::DRAIN_W-1:0]       drain_q;
    logic                              last_pair;
    logic                              drain_end;

    assign last_pair = (pair_q == fft_pkg::PAIR_W'(fft_pkg::N_POINTS / 2 - 1));
    assign drain_end = (drain_q == fft_pkg::DRAIN_W'(fft_pkg::BFLY_LATENCY - 1));

    // ------------------------------------------------------------------------
    // state sequencing
    // ------------------------------------------------------------------------
    always_comb begin
        state_d = state_q;
        case (state_q)
            fft_pkg::IDLE: begin
                if (start_i) begin
                    state_d = fft_pkg::READ_A;
                end
            end
            fft_pkg::READ_A: state_d = fft_pkg::READ_B;
            fft_pkg::READ_B: begin
                state_d = last_pair ? fft_pkg::DRAIN : fft_pkg::READ_A;
            end
            fft_pkg::DRAIN: begin
                if (drain_end) begin
                    state_d = fft_pkg::DONE;
                end
            end
            fft_pkg::DONE: state_d = fft_pkg::IDLE;
            default:       state_d = fft_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= fft_pkg::IDLE;
            pair_q  <= '0;
            drain_q <= '0;
        end else begin
            state_q <= state_d;
            // pair index advances after the odd read, wraps to 0 for the next run
            if (state_q == fft_pkg::READ_B) begin
                pair_q <= pair_q + 1'b1;
            end
            if (state_q == fft_pkg::DRAIN) begin
                drain_q <= drain_q + 1'b1;
            end else begin
                drain_q <= '0;
            end
        end
    end

    // ------------------------------------------------------------------------
    // read addressing: even sample of the pair, then the odd one
    // ------------------------------------------------------------------------
    assign rd_en_o   = (state_q == fft_pkg::READ_A) || (state_q == fft_pkg::READ_B);
    assign rd_addr_o = {pair_q, state_q == fft_pkg::READ_B};

    // strobes follow the read by one cycle, same as the bank's read latency
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            opa_stb_o <= 1'b0;
            opb_stb_o <= 1'b0;
        end else begin
            opa_stb_o <= (state_q == fft_pkg::READ_A);
            opb_stb_o <= (state_q == fft_pkg::READ_B);
        end
    end

    // angle is p mod 4, tagged together with the pair's even address
    always_ff @(posedge clk) begin
        angle_o     <= pair_q[fft_pkg::ANGLE_W-1:0];
        pair_addr_o <= {pair_q, 1'b0};
    end

    assign done_o = (state_q == fft_pkg::DONE);

endmodule

/* butterfly/radix2_butterfly.sv */
`timescale 1ns/1ps

module radix2_butterfly (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          opa_stb_i,
    input  logic                          opb_stb_i,
    input  logic [fft_pkg::ANGLE_W-1:0]   angle_i,
    input  logic [fft_pkg::ADDR_W-1:0]    pair_addr_i,
    input  fft_pkg::sample_t              op_data_i,
    sample_wr_if.writer                   wr
);

    typedef enum logic {
        WR_SUM,
        WR_DIF
    } wr_slot_e;

    fft_pkg::sample_t                      a_q;
    logic signed [fft_pkg::DATA_W-1:0]     tw_c;
    logic signed [fft_pkg::DATA_W-1:0]     tw_s;
    logic signed [fft_pkg::PROD_W-1:0]     rot_re;
    logic signed [fft_pkg::PROD_W-1:0]     rot_im;

    // stage 1: rotated operand b
    logic                                  s1_vld_q;
    fft_pkg::sample_t                      s1_a_q;
    logic [fft_pkg::ADDR_W-1:0]            s1_addr_q;
    logic signed [fft_pkg::ROT_W-1:0]      t_re_q;
    logic signed [fft_pkg::ROT_W-1:0]      t_im_q;

    // stage 2: halved sum and difference
    logic signed [fft_pkg::SUM_W-1:0]      sum_re;
    logic signed [fft_pkg::SUM_W-1:0]      sum_im;
    logic signed [fft_pkg::SUM_W-1:0]      dif_re;
    logic signed [fft_pkg::SUM_W-1:0]      dif_im;
    logic                                  s2_vld_q;
    logic [fft_pkg::ADDR_W-1:0]            s2_addr_q;
    fft_pkg::sample_t                      s2_sum_q;
    fft_pkg::sample_t                      s2_dif_q;

    // write serializer
    wr_slot_e                              slot_q;
    logic                                  wr_en_q;
    logic [fft_pkg::ADDR_W-1:0]            wr_addr_q;
    fft_pkg::sample_t                      wr_data_q;

    // ------------------------------------------------------------------------
    // complex multiply, b * (c + j*s)
    // ------------------------------------------------------------------------
    assign tw_c   = fft_pkg::TW_COS[angle_i];
    assign tw_s   = fft_pkg::TW_SIN[angle_i];
    assign rot_re = op_data_i.re * tw_c - op_data_i.im * tw_s;
    assign rot_im = op_data_i.re * tw_s + op_data_i.im * tw_c;

    assign sum_re = s1_a_q.re + t_re_q;
    assign sum_im = s1_a_q.im + t_im_q;
    assign dif_re = s1_a_q.re - t_re_q;
    assign dif_im = s1_a_q.im - t_im_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_vld_q <= 1'b0;
            s2_vld_q <= 1'b0;
        end else begin
            s1_vld_q <= opb_stb_i;
            s2_vld_q <= s1_vld_q;
        end
    end

    always_ff @(posedge clk) begin
        if (opa_stb_i) begin
            a_q <= op_data_i;
        end
        // a is carried along so the next pair's operand a may land meanwhile
        if (opb_stb_i) begin
            s1_a_q    <= a_q;
            s1_addr_q <= pair_addr_i;
            t_re_q    <= fft_pkg::ROT_W'(rot_re >>> fft_pkg::TW_FRAC);
            t_im_q    <= fft_pkg::ROT_W'(rot_im >>> fft_pkg::TW_FRAC);
        end
        if (s1_vld_q) begin
            s2_addr_q   <= s1_addr_q;
            s2_sum_q.re <= fft_pkg::DATA_W'(sum_re >>> 1);
            s2_sum_q.im <= fft_pkg::DATA_W'(sum_im >>> 1);
            s2_dif_q.re <= fft_pkg::DATA_W'(dif_re >>> 1);
            s2_dif_q.im <= fft_pkg::DATA_W'(dif_im >>> 1);
        end
    end

    // ------------------------------------------------------------------------
    // two writes per pair: half-sum to 2p, half-difference to 2p+1
    // ------------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            slot_q  <= WR_SUM;
            wr_en_q <= 1'b0;
        end else begin
            case (slot_q)
                WR_SUM: begin
                    wr_en_q <= s2_vld_q;
                    if (s2_vld_q) begin
                        slot_q <= WR_DIF;
                    end
                end
                WR_DIF: begin
                    wr_en_q <= 1'b1;
                    slot_q  <= WR_SUM;
                end
                default: begin
                    wr_en_q <= 1'b0;
                    slot_q  <= WR_SUM;
                end
            endcase
        end
    end

    // stage 2 still holds this pair in the WR_DIF cycle
    always_ff @(posedge clk) begin
        if (slot_q == WR_SUM) begin
            wr_addr_q <= s2_addr_q;
            wr_data_q <= s2_sum_q;
        end else begin
            wr_addr_q <= s2_addr_q + fft_pkg::ADDR_W'(1);
            wr_data_q <= s2_dif_q;
        end
    end

    assign wr.en   = wr_en_q;
    assign wr.addr = wr_addr_q;
    assign wr.re   = wr_data_q.re;
    assign wr.im   = wr_data_q.im;

endmodule

/* source/fft_stage_top.sv */
`timescale 1ns/1ps

module fft_stage_top (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic                                 load_en_i,
    input  logic        [fft_pkg::ADDR_W-1:0]    load_addr_i,
    input  logic signed [fft_pkg::DATA_W-1:0]    load_re_i,
    input  logic signed [fft_pkg::DATA_W-1:0]    load_im_i,
    input  logic                                 start_i,
    input  logic                                 rd_en_i,
    input  logic        [fft_pkg::ADDR_W-1:0]    rd_addr_i,
    output logic signed [fft_pkg::DATA_W-1:0]    rd_re_o,
    output logic signed [fft_pkg::DATA_W-1:0]    rd_im_o,
    output logic                                 done_o
);

    sample_wr_if load_wr ();
    sample_wr_if res_wr ();

    logic                            in_rd_en;
    logic [fft_pkg::ADDR_W-1:0]      in_rd_addr;
    fft_pkg::sample_t                in_rd_data;
    fft_pkg::sample_t                out_rd_data;
    logic                            opa_stb;
    logic                            opb_stb;
    logic [fft_pkg::ANGLE_W-1:0]     angle;
    logic [fft_pkg::ADDR_W-1:0]      pair_addr;

    // host load port into the input bank
    assign load_wr.en   = load_en_i;
    assign load_wr.addr = load_addr_i;
    assign load_wr.re   = load_re_i;
    assign load_wr.im   = load_im_i;

    sample_ram in_bank_inst (
        .clk       (clk),
        .wr        (load_wr),
        .rd_en_i   (in_rd_en),
        .rd_addr_i (in_rd_addr),
        .rd_data_o (in_rd_data)
    );

    stage_ctrl stage_ctrl_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .start_i     (start_i),
        .rd_en_o     (in_rd_en),
        .rd_addr_o   (in_rd_addr),
        .opa_stb_o   (opa_stb),
        .opb_stb_o   (opb_stb),
        .angle_o     (angle),
        .pair_addr_o (pair_addr),
        .done_o      (done_o)
    );

    radix2_butterfly radix2_butterfly_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .opa_stb_i   (opa_stb),
        .opb_stb_i   (opb_stb),
        .angle_i     (angle),
        .pair_addr_i (pair_addr),
        .op_data_i   (in_rd_data),
        .wr          (res_wr)
    );

    // results bank, read back by the host
    sample_ram out_bank_inst (
        .clk       (clk),
        .wr        (res_wr),
        .rd_en_i   (rd_en_i),
        .rd_addr_i (rd_addr_i),
        .rd_data_o (out_rd_data)
    );

    assign rd_re_o = out_rd_data.re;
    assign rd_im_o = out_rd_data.im;

endmodule

/* sim/tb_clk_gen.sv */
`timescale 1ns/1ps

module tb_clk_gen (
    input  logic rst_req_i,
    output logic clk,
    output logic rst_n
);

    localparam real HALF_PERIOD = 10.0;
    localparam int  RST_CYCLES  = 10;

    logic por_n;

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    // power-on reset released on a falling edge, away from the flop updates
    initial begin
        por_n = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        @(negedge clk);
        por_n = 1'b1;
    end

    // the testbench may pull reset again in the middle of a run
    assign rst_n = por_n & ~rst_req_i;

endmodule

/* sim/tb_fft_stage.sv */
`timescale 1ns/1ps

module tb_fft_stage;

    localparam int RUN_CYCLES     = 16 + 40 + 34;
    localparam int TIMEOUT_CYCLES = 5 * RUN_CYCLES + 100;
    localparam int DONE_WAIT_MAX  = 60;
    localparam int QUIET_CYCLES   = 30;
    localparam int RAND_SPAN      = 8000;

    logic                                 clk;
    logic                                 rst_n;
    logic                                 rst_req;
    logic                                 load_en;
    logic        [fft_pkg::ADDR_W-1:0]    load_addr;
    logic signed [fft_pkg::DATA_W-1:0]    load_re;
    logic signed [fft_pkg::DATA_W-1:0]    load_im;
    logic                                 start;
    logic                                 rd_en;
    logic        [fft_pkg::ADDR_W-1:0]    rd_addr;
    logic signed [fft_pkg::DATA_W-1:0]    rd_re;
    logic signed [fft_pkg::DATA_W-1:0]    rd_im;
    logic                                 done;

    fft_pkg::sample_t stim_q [fft_pkg::N_POINTS];
    fft_pkg::sample_t exp_q  [fft_pkg::N_POINTS];

    int value_errs  = 0;
    int other_errs  = 0;
    int cycle_cnt   = 0;

    tb_clk_gen tb_clk_gen_inst (
        .rst_req_i (rst_req),
        .clk       (clk),
        .rst_n     (rst_n)
    );

    fft_stage_top fft_stage_top_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .load_en_i   (load_en),
        .load_addr_i (load_addr),
        .load_re_i   (load_re),
        .load_im_i   (load_im),
        .start_i     (start),
        .rd_en_i     (rd_en),
        .rd_addr_i   (rd_addr),
        .rd_re_o     (rd_re),
        .rd_im_o     (rd_im),
        .done_o      (done)
    );

    // watchdog over the whole run
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout: simulation ran past %0d cycles", TIMEOUT_CYCLES);
            $display("TEST FAILED");
            $finish;
        end
    end

    // ------------------------------------------------------------------------
    // compare tasks
    // ------------------------------------------------------------------------
    task automatic check_sample(input string what, input fft_pkg::sample_t got,
                                input fft_pkg::sample_t exp);
        if (got !== exp) begin
            value_errs++;
            $display("FAILED %0t: %s got (%0d,%0d) expected (%0d,%0d)", $time, what,
                     got.re, got.im, exp.re, exp.im);
        end
    endtask

    task automatic check_bit(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            value_errs++;
            $display("FAILED %0t: %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    // ------------------------------------------------------------------------
    // stimulus and model
    // ------------------------------------------------------------------------
    task automatic fill_random();
        int r;
        for (int i = 0; i < fft_pkg::N_POINTS; i++) begin
            r = $urandom % (2 * RAND_SPAN + 1);
            stim_q[i].re = fft_pkg::DATA_W'(r - RAND_SPAN);
            r = $urandom % (2 * RAND_SPAN + 1);
            stim_q[i].im = fft_pkg::DATA_W'(r - RAND_SPAN);
        end
    endtask

    // pair p takes twiddle p mod 4 before the halved sum and difference
    task automatic compute_model();
        int ar;
        int ai;
        int br;
        int bi;
        int c;
        int s;
        int tr;
        int ti;
        for (int p = 0; p < fft_pkg::N_POINTS / 2; p++) begin
            ar = stim_q[2*p].re;
            ai = stim_q[2*p].im;
            br = stim_q[2*p+1].re;
            bi = stim_q[2*p+1].im;
            c  = fft_pkg::TW_COS[p % fft_pkg::N_ANGLES];
            s  = fft_pkg::TW_SIN[p % fft_pkg::N_ANGLES];
            tr = (br * c - bi * s) >>> fft_pkg::TW_FRAC;
            ti = (br * s + bi * c) >>> fft_pkg::TW_FRAC;
            exp_q[2*p].re   = fft_pkg::DATA_W'((ar + tr) >>> 1);
            exp_q[2*p].im   = fft_pkg::DATA_W'((ai + ti) >>> 1);
            exp_q[2*p+1].re = fft_pkg::DATA_W'((ar - tr) >>> 1);
            exp_q[2*p+1].im = fft_pkg::DATA_W'((ai - ti) >>> 1);
        end
    endtask

    task automatic load_bank();
        for (int i = 0; i < fft_pkg::N_POINTS; i++) begin
            @(negedge clk);
            load_en   = 1'b1;
            load_addr = fft_pkg::ADDR_W'(i);
            load_re   = stim_q[i].re;
            load_im   = stim_q[i].im;
        end
        @(negedge clk);
        load_en = 1'b0;
    endtask

    task automatic pulse_start();
        @(negedge clk);
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
    endtask

    task automatic wait_done(input string what);
        int n;
        n = 0;
        while (done !== 1'b1 && n < DONE_WAIT_MAX) begin
            @(negedge clk);
            n++;
        end
        if (done !== 1'b1) begin
            other_errs++;
            $display("error: done_o did not rise within %0d cycles (%s)", DONE_WAIT_MAX, what);
        end else begin
            @(negedge clk);
            check_bit({what, " done_o pulse width"}, done, 1'b0);
        end
    endtask

    // data for an address is sampled one cycle after the address is driven
    task automatic read_and_check(input string what);
        fft_pkg::sample_t got;
        @(negedge clk);
        rd_en   = 1'b1;
        rd_addr = '0;
        for (int i = 1; i <= fft_pkg::N_POINTS; i++) begin
            @(negedge clk);
            got.re = rd_re;
            got.im = rd_im;
            check_sample($sformatf("%s addr %0d", what, i - 1), got, exp_q[i-1]);
            if (i < fft_pkg::N_POINTS) begin
                rd_addr = fft_pkg::ADDR_W'(i);
            end else begin
                rd_en = 1'b0;
            end
        end
    endtask

    task automatic watch_done_low(input string what, input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            check_bit(what, done, 1'b0);
        end
    endtask

    task automatic run_and_check(input string what);
        load_bank();
        compute_model();
        pulse_start();
        wait_done(what);
        read_and_check(what);
    endtask

    // ------------------------------------------------------------------------
    // directed tests
    // ------------------------------------------------------------------------
    task automatic test_impulse();
        for (int i = 0; i < fft_pkg::N_POINTS; i++) begin
            stim_q[i] = '0;
            exp_q[i]  = '0;
        end
        stim_q[0].re = 16'sd16000;
        exp_q[0].re  = 16'sd8000;
        exp_q[1].re  = 16'sd8000;
        load_bank();
        pulse_start();
        wait_done("impulse");
        read_and_check("impulse");
    endtask

    task automatic test_random_stage();
        fill_random();
        run_and_check("random");
    endtask

    // results of the first run are read while the next data loads
    task automatic test_back_to_back();
        fill_random();
        load_bank();
        compute_model();
        pulse_start();
        wait_done("b2b first");
        fill_random();
        fork
            load_bank();
            read_and_check("b2b first");
        join
        compute_model();
        pulse_start();
        wait_done("b2b second");
        read_and_check("b2b second");
    endtask

    task automatic test_start_busy();
        fill_random();
        load_bank();
        compute_model();
        pulse_start();
        repeat (2) @(negedge clk);
        start = 1'b1;
        repeat (3) @(negedge clk);
        start = 1'b0;
        wait_done("start busy");
        watch_done_low("start busy extra done_o", QUIET_CYCLES);
        read_and_check("start busy");
    endtask

    task automatic test_reset_mid_run();
        fill_random();
        load_bank();
        pulse_start();
        repeat (5) @(negedge clk);
        rst_req = 1'b1;
        repeat (3) @(negedge clk);
        rst_req = 1'b0;
        watch_done_low("done_o after mid-run reset", QUIET_CYCLES);
        fill_random();
        run_and_check("after reset");
    endtask

    initial begin
        load_en   = 1'b0;
        load_addr = '0;
        load_re   = '0;
        load_im   = '0;
        start     = 1'b0;
        rd_en     = 1'b0;
        rd_addr   = '0;
        rst_req   = 1'b0;
        void'($urandom(32'h938fc066));

        wait (rst_n === 1'b1);
        check_bit("done_o after reset", done, 1'b0);
        @(negedge clk);

        test_impulse();
        test_random_stage();
        test_back_to_back();
        test_start_busy();
        test_reset_mid_run();

        $display("summary: %0d value errors, %0d other errors", value_errs, other_errs);
        if (value_errs + other_errs == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* filelist.f */
common/fft_pkg.sv
common/sample_wr_if.sv
source/sample_ram.sv
stage_ctrl/stage_ctrl.sv
butterfly/radix2_butterfly.sv
source/fft_stage_top.sv
sim/tb_clk_gen.sv
sim/tb_fft_stage.sv
